//--- verilog/rvPkg.sv
`default_nettype none
/* core-wide types and constants
   word, register index, instruction and ALU operation types
   opcodes, funct fields, forwarding and writeback selects */
package rvPkg;

	typedef logic [31:0] wordT;
	typedef logic [4:0] regIdxT;
	typedef logic [31:0] instrT;

	// ALU operations the decoder can ask for
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_OR,
		ALU_AND,
		ALU_SLT
	} aluOpT;

	// operand source in execute, 2'b11 is never used
	typedef enum logic [1:0] {
		FWD_REG = 2'b00,
		FWD_WB  = 2'b01,
		FWD_MEM = 2'b10
	} fwdSelT;

	// writeback result source
	typedef enum logic {
		WB_ALU,
		WB_MEM
	} wbSelT;

	// major opcodes of the supported subset
	localparam logic [6:0] OP_REG    = 7'b0110011;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_JAL    = 7'b1101111;

	// funct3 values, add and sub share one
	localparam logic [2:0] F3_ADD = 3'b000;
	localparam logic [2:0] F3_SLT = 3'b010;
	localparam logic [2:0] F3_OR  = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;
	localparam logic [2:0] F3_BEQ = 3'b000;
	localparam logic [6:0] F7_SUB = 7'b0100000;

	localparam wordT RESET_PC = 32'h0000_0000;
	// addi x0, x0, 0
	localparam instrT NOP_INSTR = 32'h0000_0013;

endpackage : rvPkg
`default_nettype wire

//--- verilog/pipeIf.sv
`timescale 1ns/1ns
`default_nettype none
/* pipeline bundles between stages
   decode-to-execute, execute-to-memory, memory-to-writeback, hazard control */

interface idExIf;
	rvPkg::wordT a, b, signImm, pcPlus4;
	rvPkg::regIdxT rs1, rs2, rd;
	logic regWrite, memToReg, memWrite, aluSrc, jump;
	rvPkg::aluOpT aluOp;
	modport src (output a, b, signImm, rs1, rs2, rd, regWrite, memToReg, memWrite,
		aluSrc, aluOp, jump, pcPlus4);
	modport dst (input a, b, signImm, rs1, rs2, rd, regWrite, memToReg, memWrite,
		aluSrc, aluOp, jump, pcPlus4);
endinterface : idExIf

interface exMemIf;
	rvPkg::wordT aluOut, writeData;
	rvPkg::regIdxT rd;
	logic regWrite, memToReg, memWrite;
	modport src (output aluOut, writeData, rd, regWrite, memToReg, memWrite);
	modport dst (input aluOut, writeData, rd, regWrite, memToReg, memWrite);
endinterface : exMemIf

interface memWbIf;
	rvPkg::wordT result;
	rvPkg::regIdxT rd;
	logic regWrite;
	modport src (output result, rd, regWrite);
	modport dst (input result, rd, regWrite);
endinterface : memWbIf

// clock only feeds the hazard checks
interface hazardIf (input logic clk);
	rvPkg::regIdxT rs1D, rs2D;
	logic usesBranchD, stallF, stallD, flushE, forwardAD, forwardBD;
	rvPkg::fwdSelT forwardAE, forwardBE;
	modport hazard (input clk, rs1D, rs2D, usesBranchD,
		output stallF, stallD, flushE, forwardAD, forwardBD, forwardAE, forwardBE);
	modport decode (output rs1D, rs2D, usesBranchD, input flushE, forwardAD, forwardBD);
	modport execute (input forwardAE, forwardBE);
endinterface : hazardIf
`default_nettype wire

//--- verilog/fetchStage.sv
`timescale 1ns/1ns
`default_nettype none
/* fetch stage
   pc register, next-pc select and fetch-to-decode register */
module fetchStage (
	input  logic clk,
	input  logic rstN,
	input  logic stallF,
	input  logic stallD,
	input  logic pcSrcD,
	input  logic jumpD,
	input  rvPkg::wordT pcBranchD,
	input  rvPkg::wordT jumpTargetD,
	input  rvPkg::instrT imemData,
	output rvPkg::wordT imemAddr,
	output rvPkg::instrT instrD,
	output rvPkg::wordT pcD,
	output rvPkg::wordT pcPlus4D
);
	rvPkg::wordT pcF, pcPlus4F, pcNext;
	logic redirect;

	assign pcPlus4F = pcF + 32'd4;
	assign imemAddr = pcF;
	assign redirect = pcSrcD | jumpD;

	// branch wins over jump, sequential fetch last
	always_comb begin
		if (pcSrcD)
			pcNext = pcBranchD;
		else if (jumpD)
			pcNext = jumpTargetD;
		else
			pcNext = pcPlus4F;
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			pcF <= rvPkg::RESET_PC;
		else if (!stallF)
			pcF <= pcNext;
	end

	// the word fetched behind a redirect is dropped
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			instrD <= rvPkg::NOP_INSTR;
		else if (!stallD)
			instrD <= redirect ? rvPkg::NOP_INSTR : imemData;
	end

	always_ff @(posedge clk) begin
		if (!stallD) begin
			pcD <= pcF;
			pcPlus4D <= pcPlus4F;
		end
	end

endmodule : fetchStage
`default_nettype wire

//--- verilog/controlDecoder.sv
`timescale 1ns/1ns
`default_nettype none
/* main and ALU decoder for the RV32I subset */
module controlDecoder (
	input  rvPkg::instrT instr,
	output logic regWrite,
	output logic memToReg,
	output logic memWrite,
	output logic aluSrc,
	output logic branch,
	output logic jump,
	output rvPkg::aluOpT aluOp
);
	logic [6:0] opcode, funct7;
	logic [2:0] funct3;
	rvPkg::aluOpT f3Op;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	// shared funct3 decode for register and immediate forms
	always_comb begin
		case (funct3)
			rvPkg::F3_SLT: f3Op = rvPkg::ALU_SLT;
			rvPkg::F3_OR:  f3Op = rvPkg::ALU_OR;
			rvPkg::F3_AND: f3Op = rvPkg::ALU_AND;
			default:       f3Op = rvPkg::ALU_ADD;
		endcase
	end

	always_comb begin
		// unknown opcodes fall through as a nop
		{regWrite, memToReg, memWrite, aluSrc, branch, jump} = 6'b0;
		aluOp = rvPkg::ALU_ADD;
		case (opcode)
			rvPkg::OP_REG: begin
				regWrite = 1'b1;
				if (funct3 == rvPkg::F3_ADD && funct7 == rvPkg::F7_SUB)
					aluOp = rvPkg::ALU_SUB;
				else
					aluOp = f3Op;
			end
			rvPkg::OP_IMM: begin
				regWrite = 1'b1;
				aluSrc = 1'b1;
				aluOp = f3Op;
			end
			rvPkg::OP_LOAD: begin
				regWrite = 1'b1;
				memToReg = 1'b1;
				aluSrc = 1'b1;
			end
			rvPkg::OP_STORE: begin
				memWrite = 1'b1;
				aluSrc = 1'b1;
			end
			// only beq, other compares stay a nop
			rvPkg::OP_BRANCH: branch = (funct3 == rvPkg::F3_BEQ);
			rvPkg::OP_JAL: begin
				regWrite = 1'b1;
				jump = 1'b1;
			end
			default: ;
		endcase
	end

endmodule : controlDecoder
`default_nettype wire

//--- verilog/regFile.sv
`timescale 1ns/1ns
`default_nettype none
/* register file, two reads and one falling-edge write */
module regFile (
	input  logic clk,
	input  logic we,
	input  rvPkg::regIdxT ra1,
	input  rvPkg::regIdxT ra2,
	input  rvPkg::regIdxT wa,
	input  rvPkg::wordT wd,
	output rvPkg::wordT rd1,
	output rvPkg::wordT rd2
);
	rvPkg::wordT regs [32];

	// written mid-cycle so decode sees the writeback value
	always_ff @(negedge clk) begin
		if (we)
			regs[wa] <= wd;
	end

	// x0 is hardwired on the read side
	assign rd1 = (ra1 != '0) ? regs[ra1] : '0;
	assign rd2 = (ra2 != '0) ? regs[ra2] : '0;

endmodule : regFile
`default_nettype wire

//--- verilog/decodeStage.sv
`timescale 1ns/1ns
`default_nettype none
/* decode stage
   operand read and bypass, immediates, branch resolve, decode-to-execute register */
module decodeStage (
	input  logic clk,
	input  logic rstN,
	input  rvPkg::instrT instrD,
	input  rvPkg::wordT pcD,
	input  rvPkg::wordT pcPlus4D,
	input  rvPkg::wordT aluOutM,
	memWbIf.dst memWb,
	hazardIf.decode hz,
	idExIf.src idEx,
	output logic pcSrcD,
	output logic jumpD,
	output rvPkg::wordT pcBranchD,
	output rvPkg::wordT jumpTargetD
);
	logic regWriteD, memToRegD, memWriteD, aluSrcD, branchD;
	rvPkg::aluOpT aluOpD;
	rvPkg::regIdxT rs1, rs2, rd;
	rvPkg::wordT rfA, rfB, aD, bD;
	rvPkg::wordT immI, immS, immB, immJ, signImmD;

	controlDecoder u_ctrl (
		.instr(instrD), .regWrite(regWriteD), .memToReg(memToRegD), .memWrite(memWriteD),
		.aluSrc(aluSrcD), .branch(branchD), .jump(jumpD), .aluOp(aluOpD)
	);

	assign rs1 = instrD[19:15];
	assign rs2 = instrD[24:20];
	assign rd = instrD[11:7];

	regFile u_rf (
		.clk(clk), .we(memWb.regWrite), .ra1(rs1), .ra2(rs2), .wa(memWb.rd),
		.wd(memWb.result), .rd1(rfA), .rd2(rfB)
	);

	// bypass from memory stage only, writeback is covered by the regfile
	assign aD = hz.forwardAD ? aluOutM : rfA;
	assign bD = hz.forwardBD ? aluOutM : rfB;

	assign immI = {{20{instrD[31]}}, instrD[31:20]};
	assign immS = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
	assign immB = {{19{instrD[31]}}, instrD[31], instrD[7], instrD[30:25], instrD[11:8], 1'b0};
	assign immJ = {{11{instrD[31]}}, instrD[31], instrD[19:12], instrD[20], instrD[30:21],
		1'b0};
	// stores carry the split immediate
	assign signImmD = memWriteD ? immS : immI;

	assign pcBranchD = pcD + immB;
	assign jumpTargetD = pcD + immJ;
	assign pcSrcD = branchD && (aD == bD);

	assign hz.rs1D = rs1;
	assign hz.rs2D = rs2;
	assign hz.usesBranchD = branchD;

	// control bits, cleared into a bubble on flush
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			{idEx.regWrite, idEx.memToReg, idEx.memWrite, idEx.aluSrc, idEx.jump} <= 5'b0;
		end else if (hz.flushE) begin
			{idEx.regWrite, idEx.memToReg, idEx.memWrite, idEx.aluSrc, idEx.jump} <= 5'b0;
		end else begin
			idEx.regWrite <= regWriteD;
			idEx.memToReg <= memToRegD;
			idEx.memWrite <= memWriteD;
			idEx.aluSrc <= aluSrcD;
			idEx.jump <= jumpD;
		end
	end

	// operands and indices
	always_ff @(posedge clk) begin
		idEx.a <= aD;
		idEx.b <= bD;
		idEx.signImm <= signImmD;
		idEx.rs1 <= rs1;
		idEx.rs2 <= rs2;
		idEx.rd <= rd;
		idEx.aluOp <= aluOpD;
		idEx.pcPlus4 <= pcPlus4D;
	end

endmodule : decodeStage
`default_nettype wire

//--- verilog/executeStage.sv
`timescale 1ns/1ns
`default_nettype none
/* execute stage
   operand forwarding, ALU, link select and execute-to-memory register */
module executeStage (
	input  logic clk,
	input  logic rstN,
	idExIf.dst idEx,
	hazardIf.execute hz,
	memWbIf.dst memWb,
	exMemIf.src exMem
);
	rvPkg::wordT srcA, srcB, aluB, aluVal, resultE;

	// operand A source
	always_comb begin
		case (hz.forwardAE)
			rvPkg::FWD_WB:  srcA = memWb.result;
			rvPkg::FWD_MEM: srcA = exMem.aluOut;
			default:        srcA = idEx.a;
		endcase
	end

	// operand B source, also the store data
	always_comb begin
		case (hz.forwardBE)
			rvPkg::FWD_WB:  srcB = memWb.result;
			rvPkg::FWD_MEM: srcB = exMem.aluOut;
			default:        srcB = idEx.b;
		endcase
	end

	assign aluB = idEx.aluSrc ? idEx.signImm : srcB;

	always_comb begin
		case (idEx.aluOp)
			rvPkg::ALU_SUB: aluVal = srcA - aluB;
			rvPkg::ALU_OR:  aluVal = srcA | aluB;
			rvPkg::ALU_AND: aluVal = srcA & aluB;
			// signed compare
			rvPkg::ALU_SLT: aluVal = {31'b0, $signed(srcA) < $signed(aluB)};
			default:        aluVal = srcA + aluB;
		endcase
	end

	// jal links pc plus four
	assign resultE = idEx.jump ? idEx.pcPlus4 : aluVal;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			{exMem.regWrite, exMem.memToReg, exMem.memWrite} <= 3'b0;
		end else begin
			exMem.regWrite <= idEx.regWrite;
			exMem.memToReg <= idEx.memToReg;
			exMem.memWrite <= idEx.memWrite;
		end
	end

	always_ff @(posedge clk) begin
		exMem.aluOut <= resultE;
		exMem.writeData <= srcB;
		exMem.rd <= idEx.rd;
	end

	// hazard unit only ever picks one of the three sources
	fwdSelValid: assert property (@(posedge clk) disable iff (!rstN)
		hz.forwardAE inside {rvPkg::FWD_REG, rvPkg::FWD_WB, rvPkg::FWD_MEM} &&
		hz.forwardBE inside {rvPkg::FWD_REG, rvPkg::FWD_WB, rvPkg::FWD_MEM});

endmodule : executeStage
`default_nettype wire

//--- verilog/memoryStage.sv
`timescale 1ns/1ns
`default_nettype none
/* memory stage
   data memory drive, memory-to-writeback register, result select */
module memoryStage (
	input  logic clk,
	input  logic rstN,
	exMemIf.dst exMem,
	input  rvPkg::wordT dmemRdata,
	output rvPkg::wordT dmemAddr,
	output rvPkg::wordT dmemWdata,
	output logic dmemWe,
	memWbIf.src memWb
);
	rvPkg::wordT readDataW, aluOutW;
	rvPkg::regIdxT rdW;
	logic regWriteW;
	rvPkg::wbSelT wbSelW;

	// memory sees the stage directly, write lands on the next rising edge
	assign dmemAddr = exMem.aluOut;
	assign dmemWdata = exMem.writeData;
	assign dmemWe = exMem.memWrite;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			regWriteW <= 1'b0;
			wbSelW <= rvPkg::WB_ALU;
		end else begin
			regWriteW <= exMem.regWrite;
			wbSelW <= exMem.memToReg ? rvPkg::WB_MEM : rvPkg::WB_ALU;
		end
	end

	always_ff @(posedge clk) begin
		readDataW <= dmemRdata;
		aluOutW <= exMem.aluOut;
		rdW <= exMem.rd;
	end

	// load data or ALU value
	assign memWb.result = (wbSelW == rvPkg::WB_MEM) ? readDataW : aluOutW;
	assign memWb.rd = rdW;
	assign memWb.regWrite = regWriteW;

endmodule : memoryStage
`default_nettype wire

//--- verilog/hazardUnit.sv
`timescale 1ns/1ns
`default_nettype none
/* hazard unit
   forwarding selects, load-use and branch stalls, execute flush */
module hazardUnit (
	hazardIf.hazard hz,
	idExIf.dst idEx,
	exMemIf.dst exMem,
	memWbIf.dst memWb
);
	logic lwStall, branchStall, exHit, memLoadHit;

	// memory stage is newer, so it wins over writeback
	function automatic rvPkg::fwdSelT pickFwd(input rvPkg::regIdxT rs);
		if (rs == '0)
			return rvPkg::FWD_REG;
		if (exMem.regWrite && exMem.rd == rs)
			return rvPkg::FWD_MEM;
		if (memWb.regWrite && memWb.rd == rs)
			return rvPkg::FWD_WB;
		return rvPkg::FWD_REG;
	endfunction

	assign hz.forwardAE = pickFwd(idEx.rs1);
	assign hz.forwardBE = pickFwd(idEx.rs2);

	// decode bypass for the beq compare
	assign hz.forwardAD = (hz.rs1D != '0) && exMem.regWrite && (exMem.rd == hz.rs1D);
	assign hz.forwardBD = (hz.rs2D != '0) && exMem.regWrite && (exMem.rd == hz.rs2D);

	// load in execute feeding decode
	assign lwStall = idEx.memToReg && (idEx.rd != '0) &&
		(idEx.rd == hz.rs1D || idEx.rd == hz.rs2D);

	// beq operands still being computed or loaded
	assign exHit = idEx.regWrite && (idEx.rd != '0) &&
		(idEx.rd == hz.rs1D || idEx.rd == hz.rs2D);
	assign memLoadHit = exMem.memToReg && (exMem.rd != '0) &&
		(exMem.rd == hz.rs1D || exMem.rd == hz.rs2D);
	assign branchStall = hz.usesBranchD && (exHit || memLoadHit);

	assign hz.stallF = lwStall | branchStall;
	assign hz.stallD = lwStall | branchStall;
	assign hz.flushE = lwStall | branchStall;

	// load then dependent beq is the longest case, two cycles
	stallBounded: assert property (@(posedge hz.clk) not (hz.stallD [*3]));

endmodule : hazardUnit
`default_nettype wire

//--- verilog/riscvCore.sv
`timescale 1ns/1ns
`default_nettype none
/* five-stage RV32I core top level
   stage, hazard unit and bundle hookup with memory ports */
module riscvCore (
	input  logic clk,
	input  logic rstN,
	output rvPkg::wordT imemAddr,
	input  rvPkg::instrT imemData,
	output rvPkg::wordT dmemAddr,
	output rvPkg::wordT dmemWdata,
	output logic dmemWe,
	input  rvPkg::wordT dmemRdata
);
	// fetch to decode
	rvPkg::instrT instrD;
	rvPkg::wordT pcD, pcPlus4D;
	// decode back to fetch
	logic pcSrcD, jumpD;
	rvPkg::wordT pcBranchD, jumpTargetD;

	idExIf idEx ();
	exMemIf exMem ();
	memWbIf memWb ();
	hazardIf hz (.clk(clk));

	fetchStage u_fetch (
		.clk(clk), .rstN(rstN),
		.stallF(hz.stallF), .stallD(hz.stallD),
		.pcSrcD(pcSrcD), .jumpD(jumpD),
		.pcBranchD(pcBranchD), .jumpTargetD(jumpTargetD),
		.imemData(imemData), .imemAddr(imemAddr),
		.instrD(instrD), .pcD(pcD), .pcPlus4D(pcPlus4D)
	);

	decodeStage u_decode (
		.clk(clk), .rstN(rstN),
		.instrD(instrD), .pcD(pcD), .pcPlus4D(pcPlus4D),
		.aluOutM(exMem.aluOut),
		.memWb(memWb), .hz(hz), .idEx(idEx),
		.pcSrcD(pcSrcD), .jumpD(jumpD),
		.pcBranchD(pcBranchD), .jumpTargetD(jumpTargetD)
	);

	executeStage u_execute (
		.clk(clk), .rstN(rstN),
		.idEx(idEx), .hz(hz), .memWb(memWb), .exMem(exMem)
	);

	memoryStage u_memory (
		.clk(clk), .rstN(rstN),
		.exMem(exMem), .dmemRdata(dmemRdata),
		.dmemAddr(dmemAddr), .dmemWdata(dmemWdata), .dmemWe(dmemWe),
		.memWb(memWb)
	);

	hazardUnit u_hazard (
		.hz(hz), .idEx(idEx), .exMem(exMem), .memWb(memWb)
	);

endmodule : riscvCore
`default_nettype wire

//--- verification/refModel.svh
/* reference model for the RV32I subset
   LFSR source, program and data generator, instruction-level execution */
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

logic [31:0] lfsrState;
rvPkg::wordT modelRegs [32];
rvPkg::wordT modelMem [DMEM_WORDS];
// stores the model made, oldest first
rvPkg::wordT expAddr [$];
rvPkg::wordT expData [$];

// galois form, taps x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsrNext(input logic [31:0] s);
	return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// one lfsr step per bit, first bit ends up as msb
function automatic logic [31:0] takeBits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		v = {v[30:0], lfsrState[0]};
		lfsrState = lfsrNext(lfsrState);
	end
	return v;
endfunction

// mostly x0..x7 so that neighbours depend on each other
function automatic rvPkg::regIdxT pickReg();
	if (takeBits(1) != 0)
		return rvPkg::regIdxT'(takeBits(3));
	return rvPkg::regIdxT'(takeBits(5));
endfunction

function automatic logic [2:0] pickAluF3();
	case (takeBits(2))
		0: return rvPkg::F3_ADD;
		1: return rvPkg::F3_SLT;
		2: return rvPkg::F3_OR;
		default: return rvPkg::F3_AND;
	endcase
endfunction

// instruction formats from the ISA manual
function automatic rvPkg::instrT rType(input logic [6:0] f7, input logic [2:0] f3,
	input rvPkg::regIdxT rd, input rvPkg::regIdxT rs1, input rvPkg::regIdxT rs2);
	return {f7, rs2, rs1, f3, rd, rvPkg::OP_REG};
endfunction

function automatic rvPkg::instrT iType(input logic [6:0] op, input logic [2:0] f3,
	input rvPkg::regIdxT rd, input rvPkg::regIdxT rs1, input logic [11:0] imm);
	return {imm, rs1, f3, rd, op};
endfunction

// sw with x0 as base
function automatic rvPkg::instrT sType(input rvPkg::regIdxT rs2, input logic [11:0] imm);
	return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], rvPkg::OP_STORE};
endfunction

function automatic rvPkg::instrT bType(input rvPkg::regIdxT rs1, input rvPkg::regIdxT rs2,
	input logic [12:0] off);
	return {off[12], off[10:5], rs2, rs1, rvPkg::F3_BEQ, off[4:1], off[11], rvPkg::OP_BRANCH};
endfunction

function automatic rvPkg::instrT jType(input rvPkg::regIdxT rd, input logic [20:0] off);
	return {off[20], off[10:1], off[11], off[19:12], rd, rvPkg::OP_JAL};
endfunction

// program layout: optional register preload, random body, register dump, self jal
task automatic buildProgram(input bit preload, output int lastIdx);
	int base, at, kind, skip, tailIdx;
	rvPkg::regIdxT rd, rs1, rs2;
	logic [2:0] f3;
	for (int i = 0; i < IMEM_WORDS; i++)
		imem[i] = rvPkg::NOP_INSTR;
	// background pattern from the byte address
	for (int i = 0; i < DMEM_WORDS; i++)
		dmemImage[i] = ~rvPkg::wordT'(i * 4);
	for (int i = 0; i < DATA_WORDS; i++)
		dmemImage[DATA_BASE / 4 + i] = takeBits(32);
	base = 0;
	// regfile is never reset, so the first program loads every register
	if (preload) begin
		for (int r = 1; r < 32; r++)
			imem[r - 1] = iType(rvPkg::OP_LOAD, 3'b010, rvPkg::regIdxT'(r), 5'd0,
				12'(DATA_BASE + 4 * r));
		base = PRO_LEN;
	end
	tailIdx = base + BODY_LEN;
	for (int i = 0; i < BODY_LEN; i++) begin
		at = base + i;
		kind = takeBits(3);
		rd = pickReg();
		rs1 = pickReg();
		rs2 = pickReg();
		f3 = pickAluF3();
		// forward only, never past the dump
		skip = 2 + takeBits(2);
		if (i + skip > BODY_LEN)
			skip = BODY_LEN - i;
		case (kind)
			0, 1: imem[at] = rType((f3 == rvPkg::F3_ADD && takeBits(1) != 0) ?
				rvPkg::F7_SUB : 7'd0, f3, rd, rs1, rs2);
			2, 3: imem[at] = iType(rvPkg::OP_IMM, f3, rd, rs1, 12'(takeBits(12)));
			4: imem[at] = iType(rvPkg::OP_LOAD, 3'b010, rd, 5'd0,
				12'(DATA_BASE + 4 * takeBits(6)));
			5: imem[at] = sType(rs2, 12'(DATA_BASE + 4 * takeBits(6)));
			6: begin
				// equal operands half the time so that some branches are taken
				if (takeBits(1) != 0)
					rs2 = rs1;
				imem[at] = bType(rs1, rs2, 13'(4 * skip));
			end
			default: imem[at] = jType(rd, 21'(4 * skip));
		endcase
	end
	for (int r = 0; r < 32; r++)
		imem[tailIdx + r] = sType(rvPkg::regIdxT'(r), 12'(DUMP_BASE + 4 * r));
	lastIdx = tailIdx + 32;
	imem[lastIdx] = jType(5'd0, 21'd0);
endtask

function automatic void setReg(input rvPkg::regIdxT rd, input rvPkg::wordT v);
	if (rd != '0)
		modelRegs[rd] = v;
endfunction

// one instruction per step until the self jal, stores queued in order
task automatic runModel(input int lastIdx);
	rvPkg::wordT pc, nextPc, a, b, opB, res, addr, immI, immS, immB, immJ;
	rvPkg::instrT ins;
	logic [6:0] op;
	logic [2:0] f3;
	rvPkg::regIdxT rd;
	for (int i = 0; i < DMEM_WORDS; i++)
		modelMem[i] = dmemImage[i];
	expAddr.delete();
	expData.delete();
	pc = rvPkg::RESET_PC;
	while (pc != rvPkg::wordT'(lastIdx * 4)) begin
		ins = imem[pc[8:2]];
		op = ins[6:0];
		f3 = ins[14:12];
		rd = ins[11:7];
		a = modelRegs[ins[19:15]];
		b = modelRegs[ins[24:20]];
		immI = {{20{ins[31]}}, ins[31:20]};
		immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		immB = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
		immJ = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
		opB = (op == rvPkg::OP_REG) ? b : immI;
		case (f3)
			3'b010: res = ($signed(a) < $signed(opB)) ? 32'd1 : 32'd0;
			3'b110: res = a | opB;
			3'b111: res = a & opB;
			// funct7 bit 5 picks sub, register form only
			default: res = (op == rvPkg::OP_REG && ins[30]) ? a - opB : a + opB;
		endcase
		nextPc = pc + 32'd4;
		case (op)
			rvPkg::OP_REG, rvPkg::OP_IMM: setReg(rd, res);
			rvPkg::OP_LOAD: begin
				addr = a + immI;
				setReg(rd, modelMem[addr[10:2]]);
			end
			rvPkg::OP_STORE: begin
				addr = a + immS;
				modelMem[addr[10:2]] = b;
				expAddr.push_back(addr);
				expData.push_back(b);
			end
			rvPkg::OP_BRANCH: begin
				if (a == b)
					nextPc = pc + immB;
			end
			rvPkg::OP_JAL: begin
				setReg(rd, pc + 32'd4);
				nextPc = pc + immJ;
			end
			default: ;
		endcase
		pc = nextPc;
	end
endtask

`endif

//--- verification/coreTb.sv
`timescale 1ns/1ns
`default_nettype none
/* testbench for the five-stage core
   clock, reset, memory models, store and fetch checks, timeout, final report */
module coreTb;
	localparam int NUM_PROGS = 4;
	localparam int BODY_LEN = 48;
	// register preload of the first program
	localparam int PRO_LEN = 31;
	// 32 dump stores and the self jal
	localparam int TAIL_LEN = 33;
	localparam int IMEM_WORDS = 128;
	localparam int DMEM_WORDS = 512;
	localparam int DATA_WORDS = 64;
	localparam int DATA_BASE = 'h400;
	localparam int DUMP_BASE = 'h600;
	// at most three cycles per instruction, plus reset and drain
	localparam int MAX_CYCLES = (PRO_LEN + NUM_PROGS * (BODY_LEN + TAIL_LEN)) * 3 + 100;
	// last store leaves memory stage within this many cycles of the self jal fetch
	localparam int DRAIN_CYCLES = 8;

	logic clk;
	logic rstN;
	rvPkg::wordT imemAddr, dmemAddr, dmemWdata, dmemRdata;
	rvPkg::instrT imemData;
	logic dmemWe;

	rvPkg::instrT imem [IMEM_WORDS];
	rvPkg::wordT dmem [DMEM_WORDS];
	// contents loaded into dmem while reset is held
	rvPkg::wordT dmemImage [DMEM_WORDS];
	int cycles = 0;
	int endIdx;

	`include "refModel.svh"

	riscvCore u_dut (
		.clk(clk),
		.rstN(rstN),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.dmemAddr(dmemAddr),
		.dmemWdata(dmemWdata),
		.dmemWe(dmemWe),
		.dmemRdata(dmemRdata)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// both memories read combinationally, word addressed
	assign imemData = imem[imemAddr[8:2]];
	assign dmemRdata = dmem[dmemAddr[10:2]];

	task automatic stopRun(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic storeAddrCheck(input rvPkg::wordT got, input rvPkg::wordT exp);
		if (got !== exp)
			stopRun($sformatf("FAIL at %0t: store address %h, expected %h", $time, got, exp));
	endtask

	task automatic storeDataCheck(input rvPkg::wordT got, input rvPkg::wordT exp);
		if (got !== exp)
			stopRun($sformatf("FAIL at %0t: store data %h, expected %h", $time, got, exp));
	endtask

	task automatic fetchAddrCheck(input rvPkg::wordT got, input rvPkg::wordT exp);
		if (got !== exp)
			stopRun($sformatf("FAIL at %0t: fetch address %h, expected %h", $time, got, exp));
	endtask

	task automatic levelCheck(input logic got, input logic exp, input string what);
		if (got !== exp)
			stopRun($sformatf("FAIL at %0t: %s is %b, expected %b", $time, what, got, exp));
	endtask

	// data memory, reloaded under reset, written at the rising edge
	always @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < DMEM_WORDS; i++)
				dmem[i] <= dmemImage[i];
		end else if (dmemWe) begin
			dmem[dmemAddr[10:2]] <= dmemWdata;
			if (expAddr.size() == 0) begin
				stopRun($sformatf("core stored %h to %h but the model made no further store",
					dmemWdata, dmemAddr));
			end else begin
				storeAddrCheck(dmemAddr, expAddr.pop_front());
				storeDataCheck(dmemWdata, expData.pop_front());
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES)
			stopRun("timeout: the core never reached the end of its program");
	end

	initial begin
		rstN = 1'b0;
		lfsrState = 32'd2;
		for (int r = 0; r < 32; r++)
			modelRegs[r] = '0;
		for (int p = 0; p < NUM_PROGS; p++) begin
			if (p > 0) begin
				@(posedge clk);
				rstN <= 1'b0;
			end
			buildProgram(p == 0, endIdx);
			runModel(endIdx);
			repeat (3) @(posedge clk);
			// reset state before release
			fetchAddrCheck(imemAddr, rvPkg::RESET_PC);
			levelCheck(dmemWe, 1'b0, "dmemWe in reset");
			rstN <= 1'b1;
			// done once the self jal is fetched
			while (imemAddr !== rvPkg::wordT'(endIdx * 4))
				@(posedge clk);
			repeat (DRAIN_CYCLES) @(posedge clk);
			if (expAddr.size() != 0)
				stopRun($sformatf("FAIL at %0t: program %0d ended with %0d stores missing",
					$time, p, expAddr.size()));
		end
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule : coreTb
`default_nettype wire

//--- build.f
+incdir+verification
verilog/rvPkg.sv
verilog/pipeIf.sv
verilog/fetchStage.sv
verilog/controlDecoder.sv
verilog/regFile.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/memoryStage.sv
verilog/hazardUnit.sv
verilog/riscvCore.sv
verification/coreTb.sv

//--- Makefile
# Verilator flow for the RV32I core and its testbench
VERILATOR ?= verilator
TOP ?= coreTb
FILELIST ?= build.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert -Wno-fatal
SRCS := $(wildcard verilog/*.sv verification/*.sv verification/*.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# the log decides, the exit status of the binary is not trusted
sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "simulation gave no verdict"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
